//--- ldst_access_unit.sv
`timescale 1ns/100ps
`include "ldst_macros.svh"

module ldst_access_unit import ldst_pkg::*; (
	input logic clock,
	input logic rst_n,

	input logic ldst_req,
	output logic ldst_busy,
	input ldst_order_t ldst_order,
	input logic [3:0] ldst_mask,
	input logic ldst_rw,
	input mmu_mode_t ldst_mmumod,
	input logic [31:0] ldst_addr,
	input logic [31:0] ldst_data,

	output logic raw_valid,
	output logic [31:0] raw_word,
	output mmu_flags_t raw_flags,
	output ldst_order_t raw_order,
	output logic [1:0] raw_byte_sel
);

	localparam int unsigned IDX_W = $clog2(`LDST_MEM_WORDS);

	logic [31:0] mem [`LDST_MEM_WORDS];

	logic [1:0] busy_cnt;
	logic s1_valid; // request captured, memory access next edge
	logic accept;

	// captured request
	ldst_order_t req_order;
	logic [3:0] req_mask;
	logic req_rw;
	mmu_mode_t req_mmumod;
	logic [31:0] req_addr;
	logic [31:0] req_data;

	logic [IDX_W-1:0] word_idx;
	mmu_flags_t flags;
	logic suppress;
	logic checked;

	assign accept = ldst_req && !ldst_busy;
	assign ldst_busy = (busy_cnt != 2'd0);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy_cnt <= 2'd0;
			s1_valid <= 1'b0;
			raw_valid <= 1'b0;
		end else begin
			if (accept)
				busy_cnt <= 2'(`LDST_BUSY_CYCLES);
			else if (busy_cnt != 2'd0)
				busy_cnt <= busy_cnt - 2'd1;
			s1_valid <= accept;
			raw_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_order <= ldst_order;
			req_mask <= ldst_mask;
			req_rw <= ldst_rw;
			req_mmumod <= ldst_mmumod;
			req_addr <= ldst_addr;
			req_data <= ldst_data;
		end
	end

	assign word_idx = req_addr[IDX_W+1:2];
	assign checked = (req_mmumod != MMU_PHYS); // physical mode bypasses the mmu

	always_comb begin
		flags = '0;
		if (checked) begin
			flags[`LDST_FLAG_FAULT] = (req_addr >= `LDST_ADDR_LIMIT);
			flags[`LDST_FLAG_PRIV] = (req_mmumod == MMU_USER) &&
				(req_addr < `LDST_USER_BASE);
			flags[`LDST_FLAG_ALIGN] = ((req_order == LDST_HALF) && req_addr[0]) ||
				((req_order == LDST_WORD) && (req_addr[1:0] != 2'b00));
		end
	end

	assign suppress = (flags != '0);

	always_ff @(posedge clock) begin
		if (s1_valid) begin
			if (req_rw && !suppress) begin
				for (int i = 0; i < 4; i++) begin
					if (req_mask[i])
						mem[word_idx][8*i +: 8] <= req_data[8*i +: 8];
				end
			end
			// writes and flagged accesses return zero
			raw_word <= (!req_rw && !suppress) ? mem[word_idx] : 32'd0;
			raw_flags <= flags;
			raw_order <= req_order;
			raw_byte_sel <= req_addr[1:0];
		end
	end

endmodule

//--- ldst_cases.txt
# sel rw order mask mode addr data exp_data exp_flags, all hex
# order 0 byte 1 half 2 word, mode 0 phys 1 user 2 kernel, flags bit0 fault bit1 priv bit2 align
0 1 2 f 2 00000100 11223344 00000000 000
0 0 2 f 2 00000100 00000000 11223344 000
0 1 0 2 1 00000101 0000aa00 00000000 000
0 0 2 f 1 00000100 00000000 1122aa44 000
0 1 1 c 2 00000102 beef0000 00000000 000
0 0 1 0 2 00000102 00000000 0000beef 000
0 0 1 0 2 00000100 00000000 0000aa44 000
0 0 0 0 2 00000103 00000000 000000be 000
0 0 0 0 1 00000101 00000000 000000aa 000
0 1 2 f 2 00000104 00000000 00000000 000
0 1 2 5 2 00000104 a1b2c3d4 00000000 000
0 0 2 f 2 00000104 00000000 00b200d4 000
1 1 2 0 2 00000104 cafef00d 00000000 000
1 0 2 0 2 00000104 00000000 cafef00d 000
1 1 2 0 0 000003f8 5a5a5a5a 00000000 000
0 0 2 f 2 00000104 00000000 cafef00d 000
0 1 2 f 2 00000500 ffffffff 00000000 001
0 1 2 f 2 000000fc 0f0f0f0f 00000000 000
0 1 2 f 1 000000fc 12345678 00000000 002
0 0 0 0 1 00000010 00000000 00000000 002
0 1 2 f 1 000004fe 00000000 00000000 005
0 0 2 f 2 000000fc 00000000 0f0f0f0f 000
0 1 1 3 2 00000101 0000ffff 00000000 004
0 1 2 f 1 00000106 ffffffff 00000000 004
0 0 2 f 1 00000012 00000000 00000000 006
0 0 2 f 2 00000100 00000000 beefaa44 000
0 0 1 0 0 00000103 00000000 0000beef 000
0 0 2 f 2 000003f8 00000000 5a5a5a5a 000
1 0 2 0 2 00000100 00000000 beefaa44 000

//--- ldst_load_align.sv
`timescale 1ns/100ps

module ldst_load_align import ldst_pkg::*; (
	input logic clock,
	input logic rst_n,

	input logic raw_valid,
	input logic [31:0] raw_word,
	input mmu_flags_t raw_flags,
	input ldst_order_t raw_order,
	input logic [1:0] raw_byte_sel,

	output logic ldst_valid,
	output mmu_flags_t ldst_flags,
	output logic [31:0] ldst_rdata
);

	logic [31:0] aligned;

	// zero extended extraction
	always_comb begin
		case (raw_order)
			LDST_BYTE: aligned = {24'd0, raw_word[8*raw_byte_sel +: 8]};
			LDST_HALF: begin
				if (raw_byte_sel[1])
					aligned = {16'd0, raw_word[31:16]};
				else
					aligned = {16'd0, raw_word[15:0]};
			end
			default: aligned = raw_word;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			ldst_valid <= 1'b0;
		else
			ldst_valid <= raw_valid;
	end

	always_ff @(posedge clock) begin
		if (raw_valid) begin
			ldst_flags <= raw_flags;
			ldst_rdata <= aligned;
		end
	end

endmodule

//--- ldst_macros.svh
`ifndef LDST_MACROS_SVH
`define LDST_MACROS_SVH

// data memory geometry
`define LDST_MEM_WORDS 256
`define LDST_ADDR_LIMIT 32'd1024

// user mode may only touch bytes from here up
`define LDST_USER_BASE 32'h100

// busy stays up this many cycles after an accept
`define LDST_BUSY_CYCLES 2

// bit positions in the mmu flag vector
`define LDST_FLAG_FAULT 0
`define LDST_FLAG_PRIV 1
`define LDST_FLAG_ALIGN 2

`endif

//--- ldst_pipe_arbiter.sv
`timescale 1ns/100ps

module ldst_pipe_arbiter import ldst_pkg::*; (
	input logic use_sel,

	// execute side
	input logic exe_req,
	output logic exe_busy,
	input ldst_order_t exe_order,
	input logic [3:0] exe_mask,
	input logic exe_rw,
	input mmu_mode_t exe_mmumod,
	input logic [31:0] exe_addr,
	input logic [31:0] exe_data,
	output logic exe_resp_valid,
	output mmu_flags_t exe_mmu_flags,
	output logic [31:0] exe_resp_data,

	// exception side
	input logic except_req,
	output logic except_busy,
	input ldst_order_t except_order,
	input logic except_rw,
	input mmu_mode_t except_mmumod,
	input logic [31:0] except_addr,
	input logic [31:0] except_data,
	output logic except_resp_valid,
	output logic [31:0] except_resp_data,

	// towards the access unit
	output logic ldst_req,
	input logic ldst_busy,
	output ldst_order_t ldst_order,
	output logic [3:0] ldst_mask,
	output logic ldst_rw,
	output mmu_mode_t ldst_mmumod,
	output logic [31:0] ldst_addr,
	output logic [31:0] ldst_data,

	// back from the aligner
	input logic ldst_valid,
	input mmu_flags_t ldst_flags,
	input logic [31:0] ldst_rdata
);

	always_comb begin
		if (use_sel) begin
			ldst_req = except_req;
			ldst_order = except_order;
			ldst_mask = 4'hf; // context save/restore is always full word
			ldst_rw = except_rw;
			ldst_mmumod = except_mmumod;
			ldst_addr = except_addr;
			ldst_data = except_data;
		end else begin
			ldst_req = exe_req;
			ldst_order = exe_order;
			ldst_mask = exe_mask;
			ldst_rw = exe_rw;
			ldst_mmumod = exe_mmumod;
			ldst_addr = exe_addr;
			ldst_data = exe_data;
		end
	end

	// deselected side sees a permanently busy unit
	assign exe_busy = use_sel ? 1'b1 : ldst_busy;
	assign except_busy = use_sel ? ldst_busy : 1'b1;

	assign exe_resp_valid = ldst_valid && !use_sel;
	assign except_resp_valid = ldst_valid && use_sel;

	assign exe_mmu_flags = ldst_flags;
	assign exe_resp_data = ldst_rdata;
	assign except_resp_data = ldst_rdata;

endmodule

//--- ldst_pkg.sv
package ldst_pkg;

	// access size
	typedef enum logic [1:0] {
		LDST_BYTE = 2'd0,
		LDST_HALF = 2'd1,
		LDST_WORD = 2'd2
	} ldst_order_t;

	// mmu translation mode, physical skips all checks
	typedef enum logic [1:0] {
		MMU_PHYS = 2'd0,
		MMU_USER = 2'd1,
		MMU_KERNEL = 2'd2
	} mmu_mode_t;

	// flags returned with each execute response, upper bits unused
	typedef logic [11:0] mmu_flags_t;

endpackage

//--- ldst_subsystem.f
+incdir+.
ldst_pkg.sv
ldst_pipe_arbiter.sv
ldst_access_unit.sv
ldst_load_align.sv
ldst_subsystem.sv
ldst_subsystem_assertions.sv
ldst_subsystem_tb.sv

//--- ldst_subsystem.sv
`timescale 1ns/100ps

module ldst_subsystem import ldst_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic use_sel, // 1 selects the exception handler

	input logic exe_req,
	output logic exe_busy,
	input ldst_order_t exe_order,
	input logic [3:0] exe_mask,
	input logic exe_rw,
	input mmu_mode_t exe_mmumod,
	input logic [31:0] exe_addr,
	input logic [31:0] exe_data,
	output logic exe_resp_valid,
	output mmu_flags_t exe_mmu_flags,
	output logic [31:0] exe_resp_data,

	input logic except_req,
	output logic except_busy,
	input ldst_order_t except_order,
	input logic except_rw,
	input mmu_mode_t except_mmumod,
	input logic [31:0] except_addr,
	input logic [31:0] except_data,
	output logic except_resp_valid,
	output logic [31:0] except_resp_data
);

	logic ldst_req;
	logic ldst_busy;
	ldst_order_t ldst_order;
	logic [3:0] ldst_mask;
	logic ldst_rw;
	mmu_mode_t ldst_mmumod;
	logic [31:0] ldst_addr;
	logic [31:0] ldst_data;

	logic raw_valid;
	logic [31:0] raw_word;
	mmu_flags_t raw_flags;
	ldst_order_t raw_order;
	logic [1:0] raw_byte_sel;

	logic ldst_valid;
	mmu_flags_t ldst_flags;
	logic [31:0] ldst_rdata;

	ldst_pipe_arbiter i_arbiter (
		.use_sel(use_sel),
		.exe_req(exe_req),
		.exe_busy(exe_busy),
		.exe_order(exe_order),
		.exe_mask(exe_mask),
		.exe_rw(exe_rw),
		.exe_mmumod(exe_mmumod),
		.exe_addr(exe_addr),
		.exe_data(exe_data),
		.exe_resp_valid(exe_resp_valid),
		.exe_mmu_flags(exe_mmu_flags),
		.exe_resp_data(exe_resp_data),
		.except_req(except_req),
		.except_busy(except_busy),
		.except_order(except_order),
		.except_rw(except_rw),
		.except_mmumod(except_mmumod),
		.except_addr(except_addr),
		.except_data(except_data),
		.except_resp_valid(except_resp_valid),
		.except_resp_data(except_resp_data),
		.ldst_req(ldst_req),
		.ldst_busy(ldst_busy),
		.ldst_order(ldst_order),
		.ldst_mask(ldst_mask),
		.ldst_rw(ldst_rw),
		.ldst_mmumod(ldst_mmumod),
		.ldst_addr(ldst_addr),
		.ldst_data(ldst_data),
		.ldst_valid(ldst_valid),
		.ldst_flags(ldst_flags),
		.ldst_rdata(ldst_rdata)
	);

	ldst_access_unit i_access (
		.clock(clock),
		.rst_n(rst_n),
		.ldst_req(ldst_req),
		.ldst_busy(ldst_busy),
		.ldst_order(ldst_order),
		.ldst_mask(ldst_mask),
		.ldst_rw(ldst_rw),
		.ldst_mmumod(ldst_mmumod),
		.ldst_addr(ldst_addr),
		.ldst_data(ldst_data),
		.raw_valid(raw_valid),
		.raw_word(raw_word),
		.raw_flags(raw_flags),
		.raw_order(raw_order),
		.raw_byte_sel(raw_byte_sel)
	);

	ldst_load_align i_align (
		.clock(clock),
		.rst_n(rst_n),
		.raw_valid(raw_valid),
		.raw_word(raw_word),
		.raw_flags(raw_flags),
		.raw_order(raw_order),
		.raw_byte_sel(raw_byte_sel),
		.ldst_valid(ldst_valid),
		.ldst_flags(ldst_flags),
		.ldst_rdata(ldst_rdata)
	);

endmodule

//--- ldst_subsystem_assertions.sv
`timescale 1ns/100ps
`include "ldst_macros.svh"

module ldst_subsystem_assertions (
	input logic clock,
	input logic rst_n,
	input logic use_sel,
	input logic ldst_req,
	input logic ldst_busy,
	input logic ldst_valid,
	input logic exe_resp_valid,
	input logic except_resp_valid
);

	localparam int LATENCY = `LDST_BUSY_CYCLES + 1;

	logic accepted;

	assign accepted = ldst_req && !ldst_busy;

	resp_latency: assert property (@(posedge clock) disable iff (!rst_n)
		ldst_valid == $past(accepted, LATENCY))
		else $error("response strobe not %0d cycles after acceptance", LATENCY);

	// selection frozen from acceptance up to the strobe
	sel_stable: assert property (@(posedge clock) disable iff (!rst_n)
		($past(accepted, 1) || $past(accepted, 2) || $past(accepted, 3)) |-> $stable(use_sel))
		else $error("use_sel changed with an access in flight");

	one_resp: assert property (@(posedge clock) !(exe_resp_valid && except_resp_valid))
		else $error("both response valids high together");

	reset_idle: assert property (@(posedge clock) !rst_n |-> !ldst_busy)
		else $error("busy high during reset");

endmodule

bind ldst_subsystem ldst_subsystem_assertions i_assertions (
	.clock(clock),
	.rst_n(rst_n),
	.use_sel(use_sel),
	.ldst_req(ldst_req),
	.ldst_busy(ldst_busy),
	.ldst_valid(ldst_valid),
	.exe_resp_valid(exe_resp_valid),
	.except_resp_valid(except_resp_valid)
);

//--- ldst_subsystem_tb.sv
`timescale 1ns/100ps
`include "ldst_macros.svh"

module ldst_subsystem_tb import ldst_pkg::*; ();

	logic clock = 1'b0;
	logic rst_n;
	logic use_sel;
	logic exe_req, exe_busy, exe_rw, exe_resp_valid;
	ldst_order_t exe_order;
	logic [3:0] exe_mask;
	mmu_mode_t exe_mmumod;
	logic [31:0] exe_addr, exe_data, exe_resp_data;
	mmu_flags_t exe_mmu_flags;
	logic except_req, except_busy, except_rw, except_resp_valid;
	ldst_order_t except_order;
	mmu_mode_t except_mmumod;
	logic [31:0] except_addr, except_data, except_resp_data;

	int edge_cnt = 0;
	int last_accept = -100;

	// accesses in flight, oldest first
	logic q_sel [$];
	logic [31:0] q_data [$];
	mmu_flags_t q_flags [$];
	int q_edge [$];

	ldst_subsystem i_dut (.*);

	always #2 clock = ~clock;

	always @(posedge clock)
		edge_cnt <= edge_cnt + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// outputs settle half a cycle before the falling edge
	task automatic check_response();
		logic exp_sel;
		logic [31:0] exp_data;
		mmu_flags_t exp_flags;
		int exp_edge;
		if (use_sel) begin
			assert (exe_busy === 1'b1) else
				abort_run($sformatf("** Error at %0t: exe_busy = %b, expected 1", $time, exe_busy));
			assert (exe_resp_valid === 1'b0) else
				abort_run($sformatf("** Error at %0t: exe_resp_valid = %b, expected 0",
					$time, exe_resp_valid));
		end else begin
			assert (except_busy === 1'b1) else
				abort_run($sformatf("** Error at %0t: except_busy = %b, expected 1",
					$time, except_busy));
			assert (except_resp_valid === 1'b0) else
				abort_run($sformatf("** Error at %0t: except_resp_valid = %b, expected 0",
					$time, except_resp_valid));
		end
		if (exe_resp_valid || except_resp_valid) begin
			assert (q_sel.size() > 0) else
				abort_run("a response strobe arrived with no access in flight");
			exp_sel = q_sel.pop_front();
			exp_data = q_data.pop_front();
			exp_flags = q_flags.pop_front();
			exp_edge = q_edge.pop_front();
			// strobe is taken on the coming rising edge
			assert (edge_cnt + 1 == exp_edge) else
				abort_run($sformatf("** Error at %0t: response edge = %0d, expected %0d",
					$time, edge_cnt + 1, exp_edge));
			if (exp_sel) begin
				assert (except_resp_data === exp_data) else
					abort_run($sformatf("** Error at %0t: except_resp_data = %h, expected %h",
						$time, except_resp_data, exp_data));
			end else begin
				assert (exe_resp_data === exp_data) else
					abort_run($sformatf("** Error at %0t: exe_resp_data = %h, expected %h",
						$time, exe_resp_data, exp_data));
				assert (exe_mmu_flags === exp_flags) else
					abort_run($sformatf("** Error at %0t: exe_mmu_flags = %h, expected %h",
						$time, exe_mmu_flags, exp_flags));
			end
		end
	endtask

	task automatic tick();
		@(negedge clock);
		check_response();
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (q_sel.size() > 0) begin
			waited++;
			assert (waited < 20) else
				abort_run("a response strobe never arrived");
			tick();
		end
	endtask

	// deselected side keeps asking for a junk write that must never land
	task automatic park_side(input logic sel);
		if (sel) begin
			exe_req = 1'b1;
			exe_rw = 1'b1;
			exe_order = LDST_WORD;
			exe_mask = 4'hf;
			exe_mmumod = MMU_PHYS;
			exe_addr = 32'h3f8;
			exe_data = 32'hbad0e0e0;
		end else begin
			except_req = 1'b1;
			except_rw = 1'b1;
			except_order = LDST_WORD;
			except_mmumod = MMU_PHYS;
			except_addr = 32'h3f8;
			except_data = 32'hbad0e1e1;
		end
	endtask

	task automatic run_case(input logic sel, input logic rw, input logic [1:0] order,
			input logic [3:0] mask, input logic [1:0] mode, input logic [31:0] addr,
			input logic [31:0] data, input logic [31:0] exp_data, input mmu_flags_t exp_flags);
		int waited;
		int accept_edge;
		bit held;
		waited = 0;
		held = 1'b0;
		if (sel != use_sel) begin
			drain(); // use_sel only moves with nothing in flight
			tick(); // last strobe still gated by the old side
		end
		use_sel = sel;
		park_side(sel);
		if (sel) begin
			except_req = 1'b1;
			except_rw = rw;
			except_order = ldst_order_t'(order);
			except_mmumod = mmu_mode_t'(mode);
			except_addr = addr;
			except_data = data;
		end else begin
			exe_req = 1'b1;
			exe_rw = rw;
			exe_order = ldst_order_t'(order);
			exe_mask = mask;
			exe_mmumod = mmu_mode_t'(mode);
			exe_addr = addr;
			exe_data = data;
		end
		#1;
		while (sel ? except_busy : exe_busy) begin
			held = 1'b1;
			waited++;
			assert (waited < 20) else
				abort_run("a held request was never accepted");
			tick();
			#1;
		end
		accept_edge = edge_cnt + 1; // taken on the coming rising edge
		if (held)
			assert (accept_edge == last_accept + `LDST_BUSY_CYCLES + 1) else
				abort_run($sformatf("** Error at %0t: accept edge = %0d, expected %0d",
					$time, accept_edge, last_accept + `LDST_BUSY_CYCLES + 1));
		last_accept = accept_edge;
		q_sel.push_back(sel);
		q_data.push_back(exp_data);
		q_flags.push_back(exp_flags);
		q_edge.push_back(accept_edge + 3);
		tick();
		if (sel)
			except_req = 1'b0;
		else
			exe_req = 1'b0;
	endtask

	initial begin
		int fd;
		int n;
		int gap;
		int case_cnt;
		string line;
		logic [31:0] col [9];
		void'($urandom(32'ha1f7ffeb));
		case_cnt = 0;
		rst_n = 1'b0;
		use_sel = 1'b0;
		exe_req = 1'b0;
		exe_rw = 1'b0;
		exe_order = LDST_BYTE;
		exe_mask = 4'h0;
		exe_mmumod = MMU_PHYS;
		exe_addr = '0;
		exe_data = '0;
		except_req = 1'b0;
		except_rw = 1'b0;
		except_order = LDST_BYTE;
		except_mmumod = MMU_PHYS;
		except_addr = '0;
		except_data = '0;
		repeat (16) @(negedge clock);
		rst_n = 1'b1;
		tick();
		assert (exe_busy === 1'b0) else
			abort_run($sformatf("** Error at %0t: exe_busy = %b, expected 0", $time, exe_busy));

		fd = $fopen("ldst_cases.txt", "r");
		assert (fd != 0) else
			abort_run("could not open ldst_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != 8'h23) begin // '#' starts a comment
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
					col[3], col[4], col[5], col[6], col[7], col[8]);
				assert (n == 9) else
					abort_run($sformatf("malformed line in the case file: %s", line));
				run_case(col[0][0], col[1][0], col[2][1:0], col[3][3:0], col[4][1:0],
					col[5], col[6], col[7], col[8][11:0]);
				case_cnt++;
				gap = $urandom_range(3, 0);
				repeat (gap) tick();
			end
		end
		$fclose(fd);
		drain();

		if (case_cnt > 0 && q_sel.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("no cases were run from the case file");
			$display("** FAIL **");
			$fatal(1);
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module ldst_subsystem_tb -f ldst_subsystem.f &&
./obj_dir/Vldst_subsystem_tb ||
{ echo "ldst_subsystem simulation failed"; exit 1; }
